// File: source/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // cache line carried on both sides of the front end
    localparam int line_width = 128;

    // cache byte address
    localparam int mem_addr_width = 27;

    // application port address, counted in half-words
    localparam int app_addr_width = 27;

    // one full cache line
    typedef logic [line_width-1:0] line_t;

    // byte address as seen by the cache
    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // half-word address driven to the memory controller
    typedef logic [app_addr_width-1:0] app_addr_t;

endpackage : mem_cfg_pkg

// File: source/ddr_app_pkg.sv
package ddr_app_pkg;

    // command field of the controller application port
    typedef logic [2:0] app_cmd_t;

    localparam app_cmd_t cmd_write = 3'b000;
    localparam app_cmd_t cmd_read  = 3'b001;

    // request sequencer states
    typedef enum logic [2:0] {
        calib,
        idle,
        // write with command and data both outstanding
        issue_cmd_wdata,
        // command outstanding, read or the rest of a write
        issue_cmd,
        // write data outstanding
        issue_wdata,
        wait_rdata
    } seq_state_t;

endpackage : ddr_app_pkg

// File: source/mem_ctrl_fsm.sv
`timescale 1ns/10ps

module mem_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic i_req,
    input  logic i_wr_en,
    input  logic i_init_calib_complete,
    input  logic i_app_rdy,
    input  logic i_app_wdf_rdy,
    input  logic i_rd_done,
    output logic o_load,
    output logic o_rd_pending,
    output logic o_app_en,
    output logic o_app_wdf_wren,
    output logic o_ack
);
    import ddr_app_pkg::*;

    seq_state_t state;
    // request in flight is a write
    logic       wr_q;
    // write completion ack
    logic       ack_q;

    // take a new request only in idle and never in the ack cycle
    assign o_load = (state == idle) && i_req && !o_ack;

    assign o_rd_pending = (state == wait_rdata);

    // a read is acked in the same cycle as read-done, so o_rdata is already valid
    assign o_ack = ack_q || ((state == wait_rdata) && i_rd_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= calib;
            wr_q           <= 1'b0;
            ack_q          <= 1'b0;
            o_app_en       <= 1'b0;
            o_app_wdf_wren <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                calib: begin
                    if (i_init_calib_complete) begin
                        state <= idle;
                    end
                end
                idle: begin
                    if (o_load) begin
                        wr_q     <= i_wr_en;
                        o_app_en <= 1'b1;
                        if (i_wr_en) begin
                            o_app_wdf_wren <= 1'b1;
                            state          <= issue_cmd_wdata;
                        end else begin
                            state <= issue_cmd;
                        end
                    end
                end
                issue_cmd_wdata: begin
                    // both sides may be taken in one cycle or one at a time
                    if (i_app_rdy && i_app_wdf_rdy) begin
                        o_app_en       <= 1'b0;
                        o_app_wdf_wren <= 1'b0;
                        ack_q          <= 1'b1;
                        state          <= idle;
                    end else if (i_app_rdy) begin
                        o_app_en <= 1'b0;
                        state    <= issue_wdata;
                    end else if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= issue_cmd;
                    end
                end
                issue_cmd: begin
                    if (i_app_rdy) begin
                        o_app_en <= 1'b0;
                        if (wr_q) begin
                            ack_q <= 1'b1;
                            state <= idle;
                        end else begin
                            state <= wait_rdata;
                        end
                    end
                end
                issue_wdata: begin
                    if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        ack_q          <= 1'b1;
                        state          <= idle;
                    end
                end
                wait_rdata: begin
                    if (i_rd_done) begin
                        state <= idle;
                    end
                end
                default: begin
                    o_app_en       <= 1'b0;
                    o_app_wdf_wren <= 1'b0;
                    state          <= idle;
                end
            endcase
        end
    end

    // nothing reaches the controller before calibration has finished
    a_no_cmd_in_calib: assert property (
        @(posedge clk) disable iff (rst)
        (state == calib) |-> !o_app_en
    );

endmodule : mem_ctrl_fsm

// File: source/app_cmd_path.sv
`timescale 1ns/10ps

module app_cmd_path (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_load,
    input  logic                   i_wr_en,
    input  mem_cfg_pkg::mem_addr_t i_addr,
    input  mem_cfg_pkg::line_t     i_wdata,
    input  logic                   i_app_en,
    input  logic                   i_app_rdy,
    output ddr_app_pkg::app_cmd_t  o_app_cmd,
    output mem_cfg_pkg::app_addr_t o_app_addr,
    output mem_cfg_pkg::line_t     o_app_wdf_data
);
    import mem_cfg_pkg::*;
    import ddr_app_pkg::*;

    // byte address to half-word units, zero-extended
    app_addr_t addr_hw;

    assign addr_hw = app_addr_t'(i_addr >> 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_app_cmd  <= cmd_write;
            o_app_addr <= '0;
        end else if (i_load) begin
            o_app_cmd  <= i_wr_en ? cmd_write : cmd_read;
            o_app_addr <= addr_hw;
        end
    end

    // write line only changes on a new request
    always_ff @(posedge clk) begin
        if (i_load) begin
            o_app_wdf_data <= i_wdata;
        end
    end

    // command must not move while the controller is stalling it
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (rst)
        (i_app_en && !i_app_rdy) |=> ($stable(o_app_cmd) && $stable(o_app_addr))
    );

endmodule : app_cmd_path

// File: source/rd_resp_path.sv
`timescale 1ns/10ps

module rd_resp_path (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_rd_pending,
    input  mem_cfg_pkg::line_t i_app_rd_data,
    input  logic               i_app_rd_data_valid,
    output mem_cfg_pkg::line_t o_rdata,
    output logic               o_rd_done
);
    import mem_cfg_pkg::*;

    // last line returned by the controller
    line_t rdata_q;

    assign o_rdata = rdata_q;

    // holds until the next read beat
    always_ff @(posedge clk) begin
        if (i_app_rd_data_valid) begin
            rdata_q <= i_app_rd_data;
        end
    end

    // completion pulse one cycle after the beat
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rd_done <= 1'b0;
        end else begin
            o_rd_done <= i_app_rd_data_valid && i_rd_pending;
        end
    end

    // controller only returns data for a read we issued
    a_valid_when_pending: assert property (
        @(posedge clk) disable iff (rst)
        i_app_rd_data_valid |-> i_rd_pending
    );

endmodule : rd_resp_path

// File: source/main_mem_ddr.sv
`timescale 1ns/10ps

module main_mem_ddr (
    input  logic                   clk,
    input  logic                   rst,

    // cache side
    input  logic                   i_req,
    input  logic                   i_wr_en,
    input  mem_cfg_pkg::mem_addr_t i_addr,
    input  mem_cfg_pkg::line_t     i_wdata,
    output logic                   o_ack,
    output mem_cfg_pkg::line_t     o_rdata,

    // memory controller application port
    input  logic                   i_init_calib_complete,
    input  logic                   i_app_rdy,
    input  logic                   i_app_wdf_rdy,
    input  mem_cfg_pkg::line_t     i_app_rd_data,
    input  logic                   i_app_rd_data_valid,
    output logic                   o_app_en,
    output ddr_app_pkg::app_cmd_t  o_app_cmd,
    output mem_cfg_pkg::app_addr_t o_app_addr,
    output logic                   o_app_wdf_wren,
    output logic                   o_app_wdf_end,
    output mem_cfg_pkg::line_t     o_app_wdf_data
);

    logic load;
    logic rd_pending;
    logic rd_done;

    // single-beat line writes, so end of data always goes with the enable
    assign o_app_wdf_end = o_app_wdf_wren;

    mem_ctrl_fsm u_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .i_req                 (i_req),
        .i_wr_en               (i_wr_en),
        .i_init_calib_complete (i_init_calib_complete),
        .i_app_rdy             (i_app_rdy),
        .i_app_wdf_rdy         (i_app_wdf_rdy),
        .i_rd_done             (rd_done),
        .o_load                (load),
        .o_rd_pending          (rd_pending),
        .o_app_en              (o_app_en),
        .o_app_wdf_wren        (o_app_wdf_wren),
        .o_ack                 (o_ack)
    );

    app_cmd_path u_cmd (
        .clk            (clk),
        .rst            (rst),
        .i_load         (load),
        .i_wr_en        (i_wr_en),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_app_en       (o_app_en),
        .i_app_rdy      (i_app_rdy),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_data (o_app_wdf_data)
    );

    rd_resp_path u_rd (
        .clk                 (clk),
        .rst                 (rst),
        .i_rd_pending        (rd_pending),
        .i_app_rd_data       (i_app_rd_data),
        .i_app_rd_data_valid (i_app_rd_data_valid),
        .o_rdata             (o_rdata),
        .o_rd_done           (rd_done)
    );

endmodule : main_mem_ddr

// File: verification/app_port_model.sv
`timescale 1ns/10ps

module app_port_model #(
    parameter int unsigned rand_seed = 32'd1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_app_en,
    input  ddr_app_pkg::app_cmd_t  i_app_cmd,
    input  mem_cfg_pkg::app_addr_t i_app_addr,
    input  logic                   i_app_wdf_wren,
    input  mem_cfg_pkg::line_t     i_app_wdf_data,
    output logic                   o_init_calib_complete,
    output logic                   o_app_rdy,
    output logic                   o_app_wdf_rdy,
    output mem_cfg_pkg::line_t     o_app_rd_data,
    output logic                   o_app_rd_data_valid,
    output int                     o_cmd_count,
    output int                     o_store_count,
    output ddr_app_pkg::app_cmd_t  o_last_cmd,
    output mem_cfg_pkg::app_addr_t o_last_addr,
    output mem_cfg_pkg::app_addr_t o_store_addr,
    output mem_cfg_pkg::line_t     o_store_data
);
    import mem_cfg_pkg::*;
    import ddr_app_pkg::*;

    // sparse line storage, unwritten lines read as zero
    line_t     mem [app_addr_t];
    int        calib_cnt;
    int        rd_wait;
    logic      cmd_pend;
    logic      data_pend;
    logic      rd_busy;
    logic      valid_nxt;
    app_addr_t pend_addr;
    app_addr_t rd_addr;
    line_t     pend_data;
    line_t     rd_data_nxt;

    initial begin
        o_init_calib_complete = 1'b0;
        o_app_rdy             = 1'b0;
        o_app_wdf_rdy         = 1'b0;
        o_app_rd_data         = '0;
        o_app_rd_data_valid   = 1'b0;
        void'($urandom(rand_seed));
        forever begin
            @(posedge clk);
            valid_nxt = 1'b0;
            if (rst) begin
                calib_cnt     = 0;
                cmd_pend      = 1'b0;
                data_pend     = 1'b0;
                rd_busy       = 1'b0;
                o_cmd_count   = 0;
                o_store_count = 0;
            end else begin
                if (rd_busy) begin
                    rd_wait--;
                    if (rd_wait == 0) begin
                        rd_busy     = 1'b0;
                        valid_nxt   = 1'b1;
                        rd_data_nxt = mem.exists(rd_addr) ? mem[rd_addr] : '0;
                    end
                end
                if (i_app_en && o_app_rdy) begin
                    o_cmd_count++;
                    o_last_cmd  = i_app_cmd;
                    o_last_addr = i_app_addr;
                    if (i_app_cmd == cmd_read) begin
                        rd_busy = 1'b1;
                        rd_addr = i_app_addr;
                        rd_wait = 1 + int'($urandom % 4);
                    end else begin
                        cmd_pend  = 1'b1;
                        pend_addr = i_app_addr;
                    end
                end
                if (i_app_wdf_wren && o_app_wdf_rdy) begin
                    data_pend = 1'b1;
                    pend_data = i_app_wdf_data;
                end
                // a write lands once both command and data are taken
                if (cmd_pend && data_pend) begin
                    mem[pend_addr] = pend_data;
                    o_store_addr   = pend_addr;
                    o_store_data   = pend_data;
                    o_store_count++;
                    cmd_pend  = 1'b0;
                    data_pend = 1'b0;
                end
                if (calib_cnt < 10) begin
                    calib_cnt++;
                end
            end
            #1;
            o_init_calib_complete = (calib_cnt == 10);
            // roughly one cycle in four stalls each side
            o_app_rdy           = ($urandom % 4) != 0;
            o_app_wdf_rdy       = ($urandom % 4) != 0;
            o_app_rd_data_valid = valid_nxt;
            if (valid_nxt) begin
                o_app_rd_data = rd_data_nxt;
            end
        end
    end

endmodule : app_port_model

// File: verification/tb_main_mem_ddr.sv
`timescale 1ns/10ps

module tb_main_mem_ddr;
    import mem_cfg_pkg::*;
    import ddr_app_pkg::*;

    localparam int          table_len = 10;
    localparam int unsigned rand_seed = 32'hc6e01748;

    localparam line_t line_a = 128'h0123456789abcdef_0011223344556677;
    localparam line_t line_b = 128'hdeadbeef00000001_cafef00d12345678;
    localparam line_t line_c = 128'hffffffffffffffff_0000000000000000;
    localparam line_t line_d = 128'h5a5a5a5a5a5a5a5a_a5a5a5a5a5a5a5a5;
    localparam line_t line_e = 128'h8000000000000000_0000000000000001;

    typedef struct packed {
        logic      wr_en;
        mem_addr_t addr;
        line_t     wdata;
        line_t     exp_rdata;
    } stim_t;

    logic      clk = 1'b0;
    logic      rst, i_req, i_wr_en, o_ack;
    mem_addr_t i_addr;
    line_t     i_wdata, o_rdata, i_app_rd_data, o_app_wdf_data, store_data;
    logic      i_init_calib_complete, i_app_rdy, i_app_wdf_rdy, i_app_rd_data_valid;
    logic      o_app_en, o_app_wdf_wren, o_app_wdf_end;
    app_cmd_t  o_app_cmd, last_cmd, held_cmd;
    app_addr_t o_app_addr, last_addr, store_addr, held_addr;
    int        cmd_count, store_count;
    stim_t     stim [table_len];
    line_t     last_rd, held_wdata;
    logic      have_rd = 1'b0;
    logic      cmd_stalled = 1'b0;
    logic      wdf_stalled = 1'b0;

    always #50 clk = ~clk;

    main_mem_ddr uut (.*);

    app_port_model #(.rand_seed(rand_seed)) u_model (
        .clk                   (clk),
        .rst                   (rst),
        .i_app_en              (o_app_en),
        .i_app_cmd             (o_app_cmd),
        .i_app_addr            (o_app_addr),
        .i_app_wdf_wren        (o_app_wdf_wren),
        .i_app_wdf_data        (o_app_wdf_data),
        .o_init_calib_complete (i_init_calib_complete),
        .o_app_rdy             (i_app_rdy),
        .o_app_wdf_rdy         (i_app_wdf_rdy),
        .o_app_rd_data         (i_app_rd_data),
        .o_app_rd_data_valid   (i_app_rd_data_valid),
        .o_cmd_count           (cmd_count),
        .o_store_count         (store_count),
        .o_last_cmd            (last_cmd),
        .o_last_addr           (last_addr),
        .o_store_addr          (store_addr),
        .o_store_data          (store_data)
    );

    task automatic fail_run(input string what);
        $display("TESTS FAILED");
        $fatal(1, "check failed: %s", what);
    endtask

    task automatic line_check(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run(what);
        end
    endtask

    task automatic addr_check(input string what, input app_addr_t got, input app_addr_t exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_run(what);
        end
    endtask

    task automatic cmd_check(input string what, input app_cmd_t got, input app_cmd_t exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run(what);
        end
    endtask

    task automatic bit_check(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_run(what);
        end
    endtask

    task automatic count_check(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run(what);
        end
    endtask

    task automatic quiet_outputs();
        bit_check("o_app_en", o_app_en, 1'b0);
        bit_check("o_app_wdf_wren", o_app_wdf_wren, 1'b0);
        bit_check("o_ack", o_ack, 1'b0);
    endtask

    // one request from raise to ack and on to the cycle after the pulse
    task automatic run_entry(input stim_t s);
        int        cmd0;
        int        store0;
        app_addr_t exp_addr;
        // zero-extended half-word address
        exp_addr = {1'b0, s.addr[mem_addr_width-1:1]};
        @(posedge clk);
        #1;
        cmd0    = cmd_count;
        store0  = store_count;
        i_req   = 1'b1;
        i_wr_en = s.wr_en;
        i_addr  = s.addr;
        i_wdata = s.wdata;
        @(negedge clk);
        while (!o_ack) begin
            @(negedge clk);
        end
        count_check("commands accepted", cmd_count - cmd0, 1);
        addr_check("accepted address", last_addr, exp_addr);
        if (s.wr_en) begin
            cmd_check("accepted command", last_cmd, cmd_write);
            count_check("lines stored", store_count - store0, 1);
            addr_check("stored address", store_addr, exp_addr);
            line_check("stored line", store_data, s.wdata);
            if (have_rd) begin
                line_check("o_rdata after write", o_rdata, last_rd);
            end
        end else begin
            cmd_check("accepted command", last_cmd, cmd_read);
            count_check("lines stored", store_count - store0, 0);
            line_check("o_rdata", o_rdata, s.exp_rdata);
            last_rd = s.exp_rdata;
            have_rd = 1'b1;
        end
        @(posedge clk);
        #1;
        i_req = 1'b0;
        @(negedge clk);
        bit_check("o_ack after its pulse", o_ack, 1'b0);
    endtask

    // stalled command and write data must hold until taken
    always @(negedge clk) begin
        if (cmd_stalled) begin
            bit_check("o_app_en under stall", o_app_en, 1'b1);
            cmd_check("o_app_cmd under stall", o_app_cmd, held_cmd);
            addr_check("o_app_addr under stall", o_app_addr, held_addr);
        end
        if (wdf_stalled) begin
            bit_check("o_app_wdf_wren under stall", o_app_wdf_wren, 1'b1);
            line_check("o_app_wdf_data under stall", o_app_wdf_data, held_wdata);
        end
        // single-beat lines end with every data beat
        if (o_app_wdf_wren) begin
            bit_check("o_app_wdf_end with write data", o_app_wdf_end, 1'b1);
        end else begin
            bit_check("o_app_wdf_end without write data", o_app_wdf_end, 1'b0);
        end
        cmd_stalled = !rst && o_app_en && !i_app_rdy;
        wdf_stalled = !rst && o_app_wdf_wren && !i_app_wdf_rdy;
        held_cmd    = o_app_cmd;
        held_addr   = o_app_addr;
        held_wdata  = o_app_wdf_data;
    end

    initial begin
        repeat (table_len * 40 + 100) @(posedge clk);
        $display("Timeout: the DUT stopped answering before the table was done");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int n_wr;
        n_wr    = 0;
        stim[0] = '{1'b1, 27'h0000100, line_a, '0};
        stim[1] = '{1'b0, 27'h0000100, '0, line_a};
        stim[2] = '{1'b0, 27'h0000200, '0, '0};
        stim[3] = '{1'b1, 27'h0000abf, line_b, '0};
        stim[4] = '{1'b1, 27'h1234567, line_c, '0};
        stim[5] = '{1'b0, 27'h0000abf, '0, line_b};
        stim[6] = '{1'b1, 27'h0000100, line_d, '0};
        stim[7] = '{1'b1, 27'h7ffffff, line_e, '0};
        stim[8] = '{1'b0, 27'h0000100, '0, line_d};
        stim[9] = '{1'b0, 27'h7ffffff, '0, line_e};
        // request already waiting while in reset
        rst     = 1'b1;
        i_req   = 1'b1;
        i_wr_en = 1'b1;
        i_addr  = 27'h0000040;
        i_wdata = line_c;
        repeat (5) begin
            @(posedge clk);
            #1;
            quiet_outputs();
        end
        rst = 1'b0;
        // calibration still running
        repeat (8) begin
            @(posedge clk);
            #1;
            bit_check("calibration done", i_init_calib_complete, 1'b0);
            quiet_outputs();
        end
        i_req = 1'b0;
        wait (i_init_calib_complete);
        for (int i = 0; i < table_len; i++) begin
            run_entry(stim[i]);
            n_wr += int'(stim[i].wr_en);
        end
        count_check("total lines stored", store_count, n_wr);
        $display("TESTS PASSED");
        $finish;
    end

endmodule : tb_main_mem_ddr

// File: files.f
source/mem_cfg_pkg.sv
source/ddr_app_pkg.sv
source/mem_ctrl_fsm.sv
source/app_cmd_path.sv
source/rd_resp_path.sv
source/main_mem_ddr.sv
verification/app_port_model.sv
verification/tb_main_mem_ddr.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_main_mem_ddr -f files.f -o sim_main_mem_ddr
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_main_mem_ddr > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
